//--- mcpu_pkg.sv
// ======================================================================
// shared encodings of the 8-bit core
// branch opcodes keep high nibble 2, the low nibble is the condition
// CC layout follows the usual 8-bit convention, bits 4 to 7 unused
// ======================================================================
package mcpu_pkg;

    typedef enum logic [7:0] {
        OP_NOP  = 8'h12,
        OP_BRA  = 8'h20,
        OP_BCC  = 8'h24,
        OP_BCS  = 8'h25,
        OP_BNE  = 8'h26,
        OP_BEQ  = 8'h27,
        OP_PSHS = 8'h34,
        OP_PULS = 8'h35,
        OP_HALT = 8'h3f,
        OP_JMP  = 8'h7e,
        OP_SUBA = 8'h80,
        OP_ANDA = 8'h84,
        OP_LDA  = 8'h86,
        OP_ADDA = 8'h8b,
        OP_LDX  = 8'h8e,
        OP_STA  = 8'hb7,
        OP_LDB  = 8'hc6
    } op_e;

    typedef enum logic [3:0] {
        COND_ALWAYS = 4'd0,
        COND_CC     = 4'd4,
        COND_CS     = 4'd5,
        COND_NE     = 4'd6,
        COND_EQ     = 4'd7
    } cond_e;

    typedef enum logic [2:0] {
        UC_FETCH, UC_OPER_HI, UC_OPER_LO, UC_EXEC, UC_STORE, UC_STACK, UC_HALTED
    } uc_state_e;

    typedef enum logic [2:0] {
        ALU_NONE, ALU_LDA, ALU_LDB, ALU_ADD, ALU_SUB, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {ADDR_PC, ADDR_OPND, ADDR_PUSH, ADDR_PULL} addr_src_e;

    typedef enum logic [2:0] {WS_A, WS_B, WS_X_HI, WS_X_LO, WS_CC} wsrc_e;

    // condition code bits
    localparam int cc_c = 0;
    localparam int cc_z = 2;
    localparam int cc_n = 3;

    // postbyte bits
    localparam int psh_cc = 0;
    localparam int psh_a  = 1;
    localparam int psh_b  = 2;
    localparam int psh_x  = 3;

endpackage

//--- mcpu_busin.sv
// ======================================================================
// opcode and operand capture from the read bus
// strobes arrive already qualified by access completion
// ======================================================================
`timescale 1ns/100ps

module mcpu_busin (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic [7:0]          rdata,
    input  logic                cap_op,
    input  logic                cap_hi,
    input  logic                cap_lo,
    output mcpu_pkg::op_e       op,
    output logic [15:0]         opnd
);
    import mcpu_pkg::*;

    always_ff @(posedge clk) begin
        if (cen) begin
            if (cap_op) begin
                op <= op_e'(rdata);
                // single byte operands see a zero high byte
                opnd[15:8] <= 8'h00;
            end
            if (cap_hi) opnd[15:8] <= rdata;
            if (cap_lo) opnd[7:0] <= rdata;
        end
    end

    // one byte per completed read
    a_one_capture: assert property (@(posedge clk) disable iff (rst)
        $onehot0({cap_op, cap_hi, cap_lo}));

endmodule

//--- mcpu_branch.sv
// ======================================================================
// branch condition check, combinational
// only Z and C are tested, opcodes outside the family give no branch
// ======================================================================
`timescale 1ns/100ps

module mcpu_branch (
    input  mcpu_pkg::op_e   op,
    input  logic [7:0]      cc,
    output logic            take
);
    import mcpu_pkg::*;

    cond_e cond;

    assign cond = cond_e'(op[3:0]);

    always_comb begin
        take = 1'b0;
        if (op[7:4] == 4'h2) begin
            case (cond)
                COND_ALWAYS: take = 1'b1;
                COND_EQ:     take = cc[cc_z];
                COND_NE:     take = !cc[cc_z];
                COND_CS:     take = cc[cc_c];
                COND_CC:     take = !cc[cc_c];
                default:     take = 1'b0;
            endcase
        end
    end

endmodule

//--- mcpu_stack.sv
// ======================================================================
// push/pull walker over the postbyte, bits 7 to 4 are ignored
// pushes run bit 3 down to 0 with X low byte first
// pulls run bit 0 up to 3 with X high byte first
// ======================================================================
`timescale 1ns/100ps

module mcpu_stack (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic [7:0]          postbyte,
    input  logic                psh_go,
    input  logic                pul_go,
    input  logic                mem_done,
    output mcpu_pkg::wsrc_e     wdata_sel,
    output mcpu_pkg::wsrc_e     pul_sel,
    output logic                stk_busy,
    output logic                push_done,
    output logic                pull_done
);
    import mcpu_pkg::*;

    logic [3:0] mask;
    logic       half;
    logic       pull;
    logic [1:0] bit_i;
    wsrc_e      cur;

    // pick the next pending bit in stack order
    always_comb begin
        bit_i = 2'd0;
        if (pull) begin
            for (int i = 3; i >= 0; i--) if (mask[i]) bit_i = i[1:0];
        end else begin
            for (int i = 0; i < 4; i++) if (mask[i]) bit_i = i[1:0];
        end
    end

    always_comb begin
        case (bit_i)
            psh_cc:  cur = WS_CC;
            psh_a:   cur = WS_A;
            psh_b:   cur = WS_B;
            default: cur = (half ^ pull) ? WS_X_HI : WS_X_LO;
        endcase
    end

    assign wdata_sel = cur;
    assign pul_sel   = cur;
    assign stk_busy  = |mask;
    assign push_done = mem_done && stk_busy && !pull;
    assign pull_done = mem_done && stk_busy && pull;

    always_ff @(posedge clk) begin
        if (rst) begin
            mask <= 4'd0;
            half <= 1'b0;
            pull <= 1'b0;
        end else if (cen) begin
            if (psh_go || pul_go) begin
                mask <= postbyte[3:0];
                half <= 1'b0;
                pull <= pul_go;
            end else if (mem_done && stk_busy) begin
                if (bit_i == psh_x && !half) begin
                    half <= 1'b1;
                end else begin
                    mask[bit_i] <= 1'b0;
                    half        <= 1'b0;
                end
            end
        end
    end

endmodule

//--- mcpu_ucode.sv
// ======================================================================
// micro-sequencer, one pass per instruction
// the opcode is decoded in OPER_HI, one cycle after its capture
// unknown opcodes run as NOP
// ======================================================================
`timescale 1ns/100ps

module mcpu_ucode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  mcpu_pkg::op_e           op,
    input  logic                    mem_done,
    input  logic                    stk_busy,
    output mcpu_pkg::uc_state_e     state,
    output logic                    rd_req,
    output logic                    wr_req,
    output mcpu_pkg::addr_src_e     addr_sel,
    output logic                    cap_op,
    output logic                    cap_hi,
    output logic                    cap_lo,
    output mcpu_pkg::alu_op_e       alu_op,
    output logic                    alu_go,
    output logic                    x_load,
    output logic                    psh_go,
    output logic                    pul_go,
    output logic                    pc_inc,
    output logic                    pc_jmp,
    output logic                    pc_branch,
    output logic                    halted
);
    import mcpu_pkg::*;

    uc_state_e nxt;
    logic      run;
    logic      wide, narrow, known, is_br, is_pul;

    assign wide   = op inside {OP_LDX, OP_STA, OP_JMP};
    assign is_br  = op inside {OP_BRA, OP_BEQ, OP_BNE, OP_BCS, OP_BCC};
    assign is_pul = (op == OP_PULS);
    assign narrow = is_br || (op inside {OP_LDA, OP_LDB, OP_ADDA, OP_SUBA, OP_ANDA,
                                         OP_PSHS, OP_PULS});
    assign known  = wide || narrow || op == OP_NOP || op == OP_HALT;

    always_comb begin
        case (op)
            OP_LDA:  alu_op = ALU_LDA;
            OP_LDB:  alu_op = ALU_LDB;
            OP_ADDA: alu_op = ALU_ADD;
            OP_SUBA: alu_op = ALU_SUB;
            OP_ANDA: alu_op = ALU_AND;
            default: alu_op = ALU_NONE;
        endcase
    end

    always_comb begin
        nxt = state;
        case (state)
            UC_FETCH:   if (mem_done) nxt = UC_OPER_HI;
            UC_OPER_HI: begin
                if (wide) nxt = mem_done ? UC_OPER_LO : UC_OPER_HI;
                else if (narrow) nxt = UC_OPER_LO;
                else if (op == OP_HALT) nxt = UC_HALTED;
                else nxt = UC_FETCH;
            end
            UC_OPER_LO: if (mem_done) nxt = (op == OP_STA) ? UC_STORE : UC_EXEC;
            UC_EXEC:    nxt = (op inside {OP_PSHS, OP_PULS}) ? UC_STACK : UC_FETCH;
            UC_STORE:   if (mem_done) nxt = UC_FETCH;
            UC_STACK:   if (!stk_busy) nxt = UC_FETCH;
            default:    nxt = UC_HALTED;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= UC_FETCH;
            run   <= 1'b0;
        end else begin
            run <= 1'b1;
            if (cen) state <= nxt;
        end
    end

    // bus requests hold for the whole state
    assign rd_req = (state == UC_FETCH && run) || (state == UC_OPER_HI && wide) ||
                    state == UC_OPER_LO || (state == UC_STACK && is_pul && stk_busy);
    assign wr_req = state == UC_STORE || (state == UC_STACK && !is_pul && stk_busy);

    always_comb begin
        case (state)
            UC_STORE: addr_sel = ADDR_OPND;
            UC_STACK: addr_sel = is_pul ? ADDR_PULL : ADDR_PUSH;
            default:  addr_sel = ADDR_PC;
        endcase
    end

    assign cap_op    = state == UC_FETCH && mem_done;
    assign cap_hi    = state == UC_OPER_HI && mem_done;
    assign cap_lo    = state == UC_OPER_LO && mem_done;
    assign pc_inc    = cap_op || cap_hi || cap_lo;
    assign alu_go    = state == UC_EXEC && alu_op != ALU_NONE;
    assign x_load    = state == UC_EXEC && op == OP_LDX;
    assign pc_jmp    = state == UC_EXEC && op == OP_JMP;
    assign pc_branch = state == UC_EXEC && is_br;
    assign psh_go    = state == UC_EXEC && op == OP_PSHS;
    assign pul_go    = state == UC_EXEC && is_pul;
    assign halted    = state == UC_HALTED;

    a_unknown_nop: assert property (@(posedge clk) disable iff (rst)
        state == UC_OPER_HI && cen && !known |=> state == UC_FETCH);

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(rd_req && wr_req));

endmodule

//--- mcpu_ctrl.sv
// ======================================================================
// control block: program counter, sequencer, branch test, stack walker
// branch offsets are relative to the byte after the offset
// ======================================================================
`timescale 1ns/100ps

module mcpu_ctrl #(
    parameter logic [15:0] reset_pc = 16'h0000
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  mcpu_pkg::op_e           op,
    input  logic [15:0]             mdata,
    input  logic [7:0]              cc,
    input  logic                    mem_done,
    output logic [15:0]             pc,
    output logic                    rd_req,
    output logic                    wr_req,
    output mcpu_pkg::addr_src_e     addr_sel,
    output mcpu_pkg::wsrc_e         wdata_sel,
    output logic                    cap_op,
    output logic                    cap_hi,
    output logic                    cap_lo,
    output mcpu_pkg::alu_op_e       alu_op,
    output logic                    alu_go,
    output logic                    x_load,
    output mcpu_pkg::wsrc_e         pul_sel,
    output logic                    pul_go,
    output logic                    push_done,
    output logic                    pull_done,
    output logic                    halted
);
    import mcpu_pkg::*;

    uc_state_e state;
    wsrc_e     stk_wsel;
    logic      psh_go, stk_busy, take;
    logic      pc_inc, pc_jmp, pc_branch;
    logic      bdone;

    // STA outside the stack sequence always writes A
    assign wdata_sel = (state == UC_STACK) ? stk_wsel : WS_A;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= reset_pc;
            bdone <= 1'b0;
        end else if (cen) begin
            if (pc_inc) pc <= pc + 16'd1;
            else if (pc_jmp) pc <= mdata;
            else if (pc_branch && take && !bdone) pc <= pc + {{8{mdata[7]}}, mdata[7:0]};
            bdone <= pc_branch && take;
        end
    end

    mcpu_ucode u_ucode (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .op        (op),
        .mem_done  (mem_done),
        .stk_busy  (stk_busy),
        .state     (state),
        .rd_req    (rd_req),
        .wr_req    (wr_req),
        .addr_sel  (addr_sel),
        .cap_op    (cap_op),
        .cap_hi    (cap_hi),
        .cap_lo    (cap_lo),
        .alu_op    (alu_op),
        .alu_go    (alu_go),
        .x_load    (x_load),
        .psh_go    (psh_go),
        .pul_go    (pul_go),
        .pc_inc    (pc_inc),
        .pc_jmp    (pc_jmp),
        .pc_branch (pc_branch),
        .halted    (halted)
    );

    mcpu_branch u_branch (
        .op   (op),
        .cc   (cc),
        .take (take)
    );

    mcpu_stack u_stack (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .postbyte  (mdata[7:0]),
        .psh_go    (psh_go),
        .pul_go    (pul_go),
        .mem_done  (mem_done),
        .wdata_sel (stk_wsel),
        .pul_sel   (pul_sel),
        .stk_busy  (stk_busy),
        .push_done (push_done),
        .pull_done (pull_done)
    );

endmodule

//--- mcpu_regs.sv
// ======================================================================
// A, B, X, S and CC with the ALU
// A, B and X come up undefined, S starts at stack_top, CC at zero
// ======================================================================
`timescale 1ns/100ps

module mcpu_regs #(
    parameter logic [15:0] stack_top = 16'h0100
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  mcpu_pkg::alu_op_e   alu_op,
    input  logic                alu_go,
    input  logic [15:0]         opnd,
    input  logic [7:0]          rdata,
    input  logic                x_load,
    input  mcpu_pkg::wsrc_e     pul_sel,
    input  logic                pul_go,
    input  logic                push_done,
    input  logic                pull_done,
    output logic [7:0]          a,
    output logic [7:0]          b,
    output logic [15:0]         x,
    output logic [15:0]         s,
    output logic [7:0]          cc
);
    import mcpu_pkg::*;

    logic [8:0] sum;
    logic [7:0] res;
    logic       pull_act;

    // bit 8 is carry for ADD, borrow for SUB
    always_comb begin
        case (alu_op)
            ALU_ADD: sum = {1'b0, a} + {1'b0, opnd[7:0]};
            ALU_SUB: sum = {1'b0, a} - {1'b0, opnd[7:0]};
            ALU_AND: sum = {1'b0, a & opnd[7:0]};
            default: sum = {1'b0, opnd[7:0]};
        endcase
    end

    assign res = sum[7:0];

    always_ff @(posedge clk) begin
        if (cen) begin
            if (alu_go && alu_op == ALU_LDB) b <= res;
            else if (alu_go && alu_op != ALU_NONE) a <= res;
            if (x_load) x <= opnd;
            if (pull_done) begin
                case (pul_sel)
                    WS_A:    a <= rdata;
                    WS_B:    b <= rdata;
                    WS_X_HI: x[15:8] <= rdata;
                    WS_X_LO: x[7:0] <= rdata;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s        <= stack_top;
            cc       <= 8'h00;
            pull_act <= 1'b0;
        end else if (cen) begin
            if (alu_go && alu_op != ALU_NONE) begin
                cc[cc_z] <= (res == 8'h00);
                cc[cc_n] <= res[7];
                if (alu_op == ALU_ADD || alu_op == ALU_SUB) cc[cc_c] <= sum[8];
            end
            if (pull_done && pul_sel == WS_CC) cc <= rdata;
            if (push_done) s <= s - 16'd1;
            else if (pull_done) s <= s + 16'd1;
            if (pul_go) pull_act <= 1'b1;
            else if (push_done || alu_go) pull_act <= 1'b0;
        end
    end

    // pulled bytes only arrive inside a PULS sequence
    a_pull_in_puls: assert property (@(posedge clk) disable iff (rst)
        pull_done |-> pull_act);

endmodule

//--- mcpu_busout.sv
// ======================================================================
// memory bus drive: address and write byte select, completion strobe
// requests are plain levels held until cen high with mem_wait low
// ======================================================================
`timescale 1ns/100ps

module mcpu_busout (
    input  logic                    clk,
    input  logic                    cen,
    input  logic                    mem_wait,
    input  logic                    rd_req,
    input  logic                    wr_req,
    input  mcpu_pkg::addr_src_e     addr_sel,
    input  mcpu_pkg::wsrc_e         wdata_sel,
    input  logic [15:0]             pc,
    input  logic [15:0]             opnd,
    input  logic [15:0]             s,
    input  logic [7:0]              a,
    input  logic [7:0]              b,
    input  logic [15:0]             x,
    input  logic [7:0]              cc,
    output logic [15:0]             addr,
    output logic                    rd,
    output logic                    wr,
    output logic [7:0]              wdata,
    output logic                    mem_done
);
    import mcpu_pkg::*;

    always_comb begin
        case (addr_sel)
            ADDR_OPND: addr = opnd;
            ADDR_PUSH: addr = s - 16'd1;
            ADDR_PULL: addr = s;
            default:   addr = pc;
        endcase
        case (wdata_sel)
            WS_B:    wdata = b;
            WS_X_HI: wdata = x[15:8];
            WS_X_LO: wdata = x[7:0];
            WS_CC:   wdata = cc;
            default: wdata = a;
        endcase
    end

    assign rd       = rd_req;
    assign wr       = wr_req;
    assign mem_done = cen && !mem_wait && (rd_req || wr_req);

    a_addr_hold: assert property (@(posedge clk)
        (rd || wr) && !mem_done |=> $stable(addr));

endmodule

//--- mcpu_top.sv
// ======================================================================
// 8-bit core top level, no interrupts
// all state advances only in cycles with cen high
// ======================================================================
`timescale 1ns/100ps

module mcpu_top #(
    parameter logic [15:0] reset_pc  = 16'h0000,
    parameter logic [15:0] stack_top = 16'h0100
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [7:0]  rdata,
    input  logic        mem_wait,
    output logic [15:0] addr,
    output logic        rd,
    output logic        wr,
    output logic [7:0]  wdata,
    output logic        halted
);
    import mcpu_pkg::*;

    op_e         op;
    alu_op_e     alu_op;
    addr_src_e   addr_sel;
    wsrc_e       wdata_sel, pul_sel;
    logic [15:0] opnd, pc, x, s;
    logic [7:0]  a, b, cc;
    logic        rd_req, wr_req, mem_done;
    logic        cap_op, cap_hi, cap_lo;
    logic        alu_go, x_load, pul_go, push_done, pull_done;

    mcpu_busin u_busin (.*);

    mcpu_ctrl #(
        .reset_pc (reset_pc)
    ) u_ctrl (
        .mdata (opnd),
        .*
    );

    mcpu_regs #(
        .stack_top (stack_top)
    ) u_regs (.*);

    mcpu_busout u_busout (.*);

endmodule

//--- mcpu_tb.sv
// ======================================================================
// self-checking testbench for the 8-bit core
// random cen and mem_wait stretch every access, each program ends in HALT
// ======================================================================
`timescale 1ns/100ps

module mcpu_tb;

    localparam logic [15:0] reset_pc  = 16'h0000;
    localparam logic [15:0] stack_top = 16'h0800;
    localparam int num_prog   = 4;
    localparam int halt_limit = 5000;
    localparam int idle_win   = 40;

    logic        clk;
    logic        rst;
    logic        cen;
    logic        mem_wait;
    logic [7:0]  rdata;
    logic [15:0] addr;
    logic        rd;
    logic        wr;
    logic [7:0]  wdata;
    logic        halted;

    logic [7:0]  mem [0:65535];
    logic [23:0] wr_trace [$];
    int          acc_cnt;
    logic [31:0] lfsr;

    // program bytes and {addr, data} pairs, packed from the right
    logic [511:0] code [num_prog];
    int           code_len [num_prog];
    logic [383:0] trace_exp [num_prog];
    int           trace_len [num_prog];

    mcpu_top #(
        .reset_pc  (reset_pc),
        .stack_top (stack_top)
    ) mcpu_top_i (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .rdata    (rdata),
        .mem_wait (mem_wait),
        .addr     (addr),
        .rd       (rd),
        .wr       (wr),
        .wdata    (wdata),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    // cen high about 3 of 4 cycles, mem_wait high about 1 of 4
    initial begin
        lfsr     = 32'h1648899b;
        cen      = 1'b0;
        mem_wait = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            cen      = next_bit() | next_bit();
            mem_wait = next_bit() & next_bit();
        end
    end

    // memory model
    assign rdata = (rd === 1'b1) ? mem[addr] : 8'h00;

    always @(posedge clk) begin
        if (rst) begin
            acc_cnt = 0;
            wr_trace.delete();
        end else if (cen && !mem_wait && (rd || wr)) begin
            acc_cnt = acc_cnt + 1;
            if (wr) begin
                mem[addr] = wdata;
                wr_trace.push_back({addr, wdata});
            end
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic build_table();
        // ALU results, carry and zero seen through BCS and BEQ
        code[0] = 512'({8'h86, 8'h05, 8'h8b, 8'h03, 8'hb7, 8'h20, 8'h00, 8'h80,
                        8'h0a, 8'hb7, 8'h20, 8'h01, 8'h84, 8'h0f, 8'hb7, 8'h20,
                        8'h02, 8'h25, 8'h05, 8'h86, 8'hee, 8'hb7, 8'h20, 8'h03,
                        8'h86, 8'hff, 8'h8b, 8'h01, 8'h27, 8'h03, 8'hb7, 8'h20,
                        8'h04, 8'h86, 8'hc3, 8'hb7, 8'h20, 8'h05, 8'h3f});
        code_len[0]  = 39;
        trace_exp[0] = 384'({24'h2000_08, 24'h2001_fe, 24'h2002_0e, 24'h2005_c3});
        trace_len[0] = 4;
        // backward BNE loop, then each branch taken and not taken
        code[1] = 512'({8'h86, 8'h03, 8'hb7, 8'h21, 8'h00, 8'h80, 8'h01, 8'h26,
                        8'hf9, 8'h25, 8'h03, 8'hb7, 8'h21, 8'h01, 8'h24, 8'h03,
                        8'hb7, 8'h21, 8'h02, 8'h86, 8'h40, 8'h27, 8'h03, 8'hb7,
                        8'h21, 8'h03, 8'h80, 8'h41, 8'h24, 8'h03, 8'hb7, 8'h21,
                        8'h04, 8'h26, 8'h03, 8'hb7, 8'h21, 8'h05, 8'h20, 8'h03,
                        8'hb7, 8'h21, 8'h06, 8'h3f});
        code_len[1]  = 44;
        trace_exp[1] = 384'({24'h2100_03, 24'h2100_02, 24'h2100_01, 24'h2101_00,
                             24'h2103_40, 24'h2104_ff});
        trace_len[1] = 6;
        // JMP over a store and a HALT
        code[2] = 512'({8'h86, 8'h11, 8'h7e, 8'h00, 8'h0a, 8'hb7, 8'h22, 8'h00,
                        8'h3f, 8'h12, 8'hb7, 8'h22, 8'h01, 8'h86, 8'h22, 8'hb7,
                        8'h22, 8'h02, 8'h12, 8'h3f});
        code_len[2]  = 20;
        trace_exp[2] = 384'({24'h2201_11, 24'h2202_22});
        trace_len[2] = 2;
        // push all, clobber, pull all, push again to show restored CC, A, B, X, S
        code[3] = 512'({8'h8e, 8'h12, 8'h34, 8'hc6, 8'h5a, 8'h86, 8'hf0, 8'h8b,
                        8'h20, 8'h34, 8'h0f, 8'h86, 8'h00, 8'hc6, 8'h80, 8'h8e,
                        8'hab, 8'hcd, 8'h35, 8'h0f, 8'hb7, 8'h23, 8'h00, 8'h34,
                        8'h0f, 8'h3f});
        code_len[3]  = 26;
        trace_exp[3] = 384'({24'h07ff_34, 24'h07fe_12, 24'h07fd_5a, 24'h07fc_10,
                             24'h07fb_01, 24'h2300_10, 24'h07ff_34, 24'h07fe_12,
                             24'h07fd_5a, 24'h07fc_10, 24'h07fb_01});
        trace_len[3] = 11;
    endtask

    task automatic load_program(input int p);
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[15:8] ^ i[7:0] ^ 8'h5a;
        end
        for (int i = 0; i < code_len[p]; i++) begin
            mem[reset_pc + i] = code[p][8*(code_len[p]-1-i) +: 8];
        end
    endtask

    task automatic run_program(input int p);
        int          wait_cnt;
        int          halt_acc;
        logic [23:0] exp_pair;
        rst = 1'b1;
        load_program(p);
        repeat (16) next_cycle();
        rst = 1'b0;
        wait_cnt = 0;
        while (halted !== 1'b1) begin
            next_cycle();
            wait_cnt++;
            if (wait_cnt > halt_limit) begin
                fail_run($sformatf("timeout: program %0d never reached HALT", p));
            end
        end
        // bus must stay idle once halted
        halt_acc = acc_cnt;
        repeat (idle_win) next_cycle();
        check_value(acc_cnt, halt_acc, "access count after halt");
        check_value(32'(halted), 32'd1, "halted");
        if (wr_trace.size() != trace_len[p]) begin
            fail_run($sformatf("program %0d made %0d writes but %0d were expected",
                               p, wr_trace.size(), trace_len[p]));
        end
        for (int j = 0; j < trace_len[p]; j++) begin
            exp_pair = trace_exp[p][24*(trace_len[p]-1-j) +: 24];
            check_value(32'(wr_trace[j]), 32'(exp_pair),
                        $sformatf("program %0d write %0d {addr,data}", p, j));
        end
    endtask

    initial begin
        rst = 1'b1;
        build_table();
        for (int p = 0; p < num_prog; p++) begin
            run_program(p);
            $display("program %0d done at %0t ns", p, $time);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- mcpu.f
mcpu_pkg.sv
mcpu_busin.sv
mcpu_branch.sv
mcpu_stack.sv
mcpu_ucode.sv
mcpu_ctrl.sv
mcpu_regs.sv
mcpu_busout.sv
mcpu_top.sv
mcpu_tb.sv
